// File: include/egress_settings.svh
/* Build-time sizes of the egress router. EGR_NUM_PORTS and EGR_BUF_WORDS must be
   powers of two, and EGR_BUF_WORDS is also the credit count the core starts with */
`ifndef EGRESS_SETTINGS_SVH
`define EGRESS_SETTINGS_SVH

// Physical ports, each one byte wide
`define EGR_NUM_PORTS 4

// Bytes in one word from the switching core
`define EGR_BUS_BYTES 8

// Words per port buffer
`define EGR_BUF_WORDS 16

// Packet and drop counter width
`define EGR_CNT_WIDTH 16

`endif

// File: hw/egress_pkg.sv
/* Types shared by the egress router and its testbench. Keep bits of a word must be
   contiguous from byte 0 with at least one set */
`include "egress_settings.svh"

package egress_pkg;

    // Width of the port number field
    localparam int EGR_PORT_W = $clog2(`EGR_NUM_PORTS);

    // One word from the switching core
    typedef struct packed {
        logic [`EGR_BUS_BYTES*8-1:0] data;
        logic [`EGR_BUS_BYTES-1:0]   keep;
        logic                        last;
        logic [EGR_PORT_W-1:0]       port;
    } egr_word_t;

    // One beat on a physical port
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } egr_byte_t;

    // One bit per physical port
    typedef logic [`EGR_NUM_PORTS-1:0] egr_port_vec_t;

    typedef logic [`EGR_CNT_WIDTH-1:0] egr_cnt_t;

endpackage

// File: hw/egress_demux.sv
/* The core may only send to a port while it holds a credit. Occupancy kept here
   is the only full check in the egress path; a word that meets a full buffer is lost */
`timescale 1ns/1ns
`include "egress_settings.svh"

module egress_demux import egress_pkg::*; (
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  logic          in_valid,
    input  egr_word_t     in_word,
    input  egr_port_vec_t port_enable,
    input  egr_port_vec_t pop,
    output egr_port_vec_t wr_valid,
    output egr_word_t     wr_word,
    output egr_port_vec_t credit_return,
    output egr_port_vec_t buf_full_drop,
    output egr_port_vec_t pkt_dropped
);

    localparam int CNT_W = $clog2(`EGR_BUF_WORDS + 1);
    // Room for credits owed when pops and drops land together
    localparam int DUE_W = CNT_W + 1;

    egr_port_vec_t    in_pkt;
    egr_port_vec_t    en_lat;
    logic [CNT_W-1:0] occ [`EGR_NUM_PORTS];
    logic [DUE_W-1:0] due [`EGR_NUM_PORTS];

    egr_port_vec_t    hit;
    egr_port_vec_t    first;
    egr_port_vec_t    pass;
    egr_port_vec_t    accept;
    egr_port_vec_t    full_drop;
    egr_port_vec_t    dis_drop;
    logic [DUE_W-1:0] due_sum [`EGR_NUM_PORTS];

    ////////////////////////////////////////
    // Per-port decision for the incoming word

    always_comb begin
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            hit[p]       = in_valid && (in_word.port == EGR_PORT_W'(p));
            // Enable is taken on the first word and held for the rest of the packet
            first[p]     = !in_pkt[p];
            pass[p]      = first[p] ? port_enable[p] : en_lat[p];
            accept[p]    = hit[p] && pass[p] && (occ[p] != CNT_W'(`EGR_BUF_WORDS));
            full_drop[p] = hit[p] && pass[p] && (occ[p] == CNT_W'(`EGR_BUF_WORDS));
            dis_drop[p]  = hit[p] && !pass[p];
            // Credits owed from earlier cycles plus a pop and a disabled drop this cycle
            due_sum[p]   = due[p] + DUE_W'(dis_drop[p]) + DUE_W'(pop[p]);
        end
    end

    ////////////////////////////////////////
    // Control state and credit return

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            in_pkt        <= '0;
            en_lat        <= '0;
            wr_valid      <= '0;
            credit_return <= '0;
            buf_full_drop <= '0;
            pkt_dropped   <= '0;
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                occ[p] <= '0;
                due[p] <= '0;
            end
        end else begin
            wr_valid      <= accept;
            buf_full_drop <= full_drop;
            // One pulse per disabled packet
            pkt_dropped   <= dis_drop & first;
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                if (hit[p]) begin
                    in_pkt[p] <= !in_word.last;
                    if (first[p]) begin
                        en_lat[p] <= port_enable[p];
                    end
                end
                occ[p]           <= occ[p] + CNT_W'(accept[p]) - CNT_W'(pop[p]);
                credit_return[p] <= (due_sum[p] != '0);
                due[p]           <= due_sum[p] - DUE_W'(due_sum[p] != '0);
            end
        end
    end

    // Shared write word qualified per port by wr_valid
    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            wr_word <= in_word;
        end
    end

endmodule

// File: hw/egress_port_buffer.sv
/* Writes are never refused here; the demux occupancy count keeps the FIFO from
   overfilling. Keep bits must be contiguous from byte 0 with at least one set */
`timescale 1ns/1ns
`include "egress_settings.svh"

module egress_port_buffer import egress_pkg::*; (
    input  logic      core_clk_ifc,
    input  logic      rst_n,
    input  logic      wr_valid,
    input  egr_word_t wr_word,
    output logic      pop,
    output logic      out_valid,
    output egr_byte_t out_byte,
    input  logic      out_ready
);

    localparam int PTR_W = $clog2(`EGR_BUF_WORDS);
    localparam int CNT_W = $clog2(`EGR_BUF_WORDS + 1);
    localparam int IDX_W = $clog2(`EGR_BUS_BYTES);

    egr_word_t        mem [`EGR_BUF_WORDS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [IDX_W-1:0] byte_idx;

    egr_word_t        head;
    logic             final_byte;
    logic             xfer;

    ////////////////////////////////////////
    // Word storage

    always_ff @(posedge core_clk_ifc) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    assign head = mem[rd_ptr];

    ////////////////////////////////////////
    // Serializer

    // Final kept byte of the head word
    always_comb begin
        final_byte = 1'b1;
        if (int'(byte_idx) < `EGR_BUS_BYTES - 1) begin
            final_byte = !head.keep[byte_idx + 1'b1];
        end
    end

    assign out_valid     = (count != '0);
    assign out_byte.data = head.data[byte_idx*8 +: 8];
    // Packet end only on the final byte of a word marked last
    assign out_byte.last = final_byte && head.last;

    assign xfer = out_valid && out_ready;
    assign pop  = xfer && final_byte;

    ////////////////////////////////////////
    // Pointers and byte index

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            byte_idx <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (xfer) begin
                if (final_byte) begin
                    // Head word done, move to the next one
                    byte_idx <= '0;
                    rd_ptr   <= rd_ptr + 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
            count <= count + CNT_W'(wr_valid) - CNT_W'(pop);
        end
    end

endmodule

// File: hw/egress_pkt_counters.sv
/* Counts saturate at full scale. A clear wins over an event in the same cycle */
`timescale 1ns/1ns
`include "egress_settings.svh"

module egress_pkt_counters import egress_pkg::*; (
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  egr_port_vec_t out_valid,
    input  egr_port_vec_t out_ready,
    input  egr_port_vec_t out_last,
    input  egr_port_vec_t pkt_dropped,
    input  egr_port_vec_t cnt_clear,
    output egr_cnt_t      pkt_cnt [`EGR_NUM_PORTS],
    output egr_cnt_t      drop_cnt [`EGR_NUM_PORTS]
);

    egr_port_vec_t pkt_done;

    // Saturating increment
    function automatic egr_cnt_t sat_inc(input egr_cnt_t cnt, input logic inc);
        if (inc && (cnt != '1)) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    // Last beat of a packet accepted by the port
    assign pkt_done = out_valid & out_ready & out_last;

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                pkt_cnt[p]  <= '0;
                drop_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                if (cnt_clear[p]) begin
                    pkt_cnt[p]  <= '0;
                    drop_cnt[p] <= '0;
                end else begin
                    pkt_cnt[p]  <= sat_inc(pkt_cnt[p], pkt_done[p]);
                    drop_cnt[p] <= sat_inc(drop_cnt[p], pkt_dropped[p]);
                end
            end
        end
    end

endmodule

// File: hw/egress_router.sv
/* Egress stage. The core gets no ready and must track credits per port;
   all ports run on core_clk_ifc */
`timescale 1ns/1ns
`include "egress_settings.svh"

module egress_router import egress_pkg::*; (
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  logic          in_valid,
    input  egr_word_t     in_word,
    output egr_port_vec_t credit_return,
    input  egr_port_vec_t port_enable,
    output egr_port_vec_t out_valid,
    output egr_byte_t     out_byte [`EGR_NUM_PORTS],
    input  egr_port_vec_t out_ready,
    output egr_port_vec_t buf_full_drop,
    input  egr_port_vec_t cnt_clear,
    output egr_cnt_t      pkt_cnt [`EGR_NUM_PORTS],
    output egr_cnt_t      drop_cnt [`EGR_NUM_PORTS]
);

    egr_port_vec_t wr_valid;
    egr_word_t     wr_word;
    egr_port_vec_t pop;
    egr_port_vec_t pkt_dropped;
    egr_port_vec_t out_last;

    egress_demux i_demux (
        .core_clk_ifc  (core_clk_ifc),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .port_enable   (port_enable),
        .pop           (pop),
        .wr_valid      (wr_valid),
        .wr_word       (wr_word),
        .credit_return (credit_return),
        .buf_full_drop (buf_full_drop),
        .pkt_dropped   (pkt_dropped)
    );

    ////////////////////////////////////////
    // One buffer per physical port

    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_port
        egress_port_buffer i_buf (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .wr_valid     (wr_valid[p]),
            .wr_word      (wr_word),
            .pop          (pop[p]),
            .out_valid    (out_valid[p]),
            .out_byte     (out_byte[p]),
            .out_ready    (out_ready[p])
        );

        assign out_last[p] = out_byte[p].last;
    end

    egress_pkt_counters i_counters (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .pkt_dropped  (pkt_dropped),
        .cnt_clear    (cnt_clear),
        .pkt_cnt      (pkt_cnt),
        .drop_cnt     (drop_cnt)
    );

endmodule

// File: dv/egress_router_assertions.sv
/* Port checks bound to the egress router. Credit bookkeeping counts every word
   sent, so returns may never outrun the words the core has sent to a port */
`timescale 1ns/1ns
`include "egress_settings.svh"

module egress_router_assertions import egress_pkg::*; (
    input logic          core_clk_ifc,
    input logic          rst_n,
    input logic          in_valid,
    input egr_word_t     in_word,
    input egr_port_vec_t credit_return,
    input egr_port_vec_t out_valid,
    input egr_byte_t     out_byte [`EGR_NUM_PORTS],
    input egr_port_vec_t out_ready
);

    // Words sent per port and not yet credited back
    int owed [`EGR_NUM_PORTS];

    always_ff @(posedge core_clk_ifc) begin
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            if (!rst_n) begin
                owed[p] <= 0;
            end else begin
                owed[p] <= owed[p] + int'(in_valid && (in_word.port == EGR_PORT_W'(p)))
                           - int'(credit_return[p]);
            end
        end
    end

    reset_no_credit: assert property (@(posedge core_clk_ifc)
        !rst_n ##1 !rst_n |-> credit_return == '0)
        else $error("credit_return active during reset");

    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_port
        beat_hold: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_byte[p]))
            else $error("beat on port %0d changed while stalled", p);

        credit_bound: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
            credit_return[p] |-> owed[p] > 0)
            else $error("credit on port %0d returned beyond words sent", p);
    end

endmodule

bind egress_router egress_router_assertions i_assertions (.*);

// File: dv/egress_router_tb.sv
/* Directed tests for the egress router. Inputs change on the falling edge and
   outputs are sampled on the rising edge; words go out only with a credit */
`timescale 1ns/1ns
`include "egress_settings.svh"

module egress_router_tb import egress_pkg::*; ();

    localparam int NP      = `EGR_NUM_PORTS;
    localparam int NB      = `EGR_BUS_BYTES;
    localparam int BW      = `EGR_BUF_WORDS;
    localparam int TIMEOUT = 4000;

    logic          core_clk_ifc;
    logic          rst_n;
    logic          in_valid;
    egr_word_t     in_word;
    egr_port_vec_t credit_return;
    egr_port_vec_t port_enable;
    egr_port_vec_t out_valid;
    egr_byte_t     out_byte [NP];
    egr_port_vec_t out_ready;
    egr_port_vec_t buf_full_drop;
    egr_port_vec_t cnt_clear;
    egr_cnt_t      pkt_cnt [NP];
    egr_cnt_t      drop_cnt [NP];

    // Core model and scoreboard
    int          credits [NP];
    int          words_sent [NP];
    int          cr_total [NP];
    int          bfd_total [NP];
    int          pkts_done [NP];
    logic [7:0]  pending_q [NP][$];
    egr_byte_t   exp_q [NP][$];
    logic [31:0] lcg_state;
    string       test_name;
    int          n_value_err;
    int          n_other_err;

    egress_router i_dut (.*);

    always #5 core_clk_ifc = ~core_clk_ifc;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void check_eq(input string what, input logic [31:0] exp,
                                     input logic [31:0] act);
        assert (exp == act) else begin
            n_value_err++;
            $display("Fail %s: %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endfunction

    function automatic void note_error(input string msg);
        n_other_err++;
        $display("%s: %s", test_name, msg);
    endfunction

    function automatic void clear_tallies();
        for (int p = 0; p < NP; p++) begin
            words_sent[p] = 0;
            cr_total[p]   = 0;
            bfd_total[p]  = 0;
            pkts_done[p]  = 0;
        end
    endfunction

    ////////////////////////////////////////
    // Output monitor and credit tracking

    always @(posedge core_clk_ifc) begin
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (credit_return[p]) begin
                    credits[p]++;
                    cr_total[p]++;
                end
                if (buf_full_drop[p]) begin
                    bfd_total[p]++;
                end
                assert (!out_valid[p] || exp_q[p].size() != 0)
                    else note_error($sformatf("out_valid on port %0d with no byte due", p));
                if (out_valid[p] && out_ready[p] && exp_q[p].size() != 0) begin
                    check_eq($sformatf("byte on port %0d", p), 32'(exp_q[p].pop_front()),
                             32'(out_byte[p]));
                    if (out_byte[p].last) begin
                        pkts_done[p]++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Core-side stimulus

    // Random packet bytes queued for sending and for the scoreboard
    function automatic void make_packet(input int port, input int len, input bit expect_out);
        egr_byte_t e;
        for (int i = 0; i < len; i++) begin
            e.data = 8'(next_rand() >> 8);
            e.last = (i == len - 1);
            pending_q[port].push_back(e.data);
            if (expect_out) begin
                exp_q[port].push_back(e);
            end
        end
    endfunction

    // Next word of the port's pending packet with keep trimmed to the bytes left
    task automatic send_next_word(input int port, input bit need_credit);
        egr_word_t w;
        int        n;
        int        t;
        w = '0;
        n = 0;
        t = 0;
        while (need_credit && credits[port] == 0 && t < TIMEOUT) begin
            @(negedge core_clk_ifc);
            t++;
        end
        assert (!need_credit || credits[port] != 0) else begin
            note_error($sformatf("no credit for port %0d before timeout", port));
            pending_q[port].delete();
            return;
        end
        while (pending_q[port].size() != 0 && n < NB) begin
            w.data[n*8 +: 8] = pending_q[port].pop_front();
            w.keep[n]        = 1'b1;
            n++;
        end
        w.last   = (pending_q[port].size() == 0);
        w.port   = EGR_PORT_W'(port);
        in_word  = w;
        in_valid = 1'b1;
        credits[port]--;
        words_sent[port]++;
        @(negedge core_clk_ifc);
        in_valid = 1'b0;
    endtask

    // Word-by-word round robin over all ports with bytes pending
    task automatic send_all();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (pending_q[p].size() != 0) begin
                    send_next_word(p, 1'b1);
                    busy = 1'b1;
                end
            end
        end
    endtask

    // All expected bytes out and all credits home
    task automatic wait_idle();
        int t;
        bit idle;
        t    = 0;
        idle = 1'b0;
        while (!idle && t < TIMEOUT) begin
            @(negedge core_clk_ifc);
            t++;
            idle = 1'b1;
            for (int p = 0; p < NP; p++) begin
                if (exp_q[p].size() != 0 || credits[p] != BW) begin
                    idle = 1'b0;
                end
            end
        end
        for (int p = 0; p < NP; p++) begin
            assert (exp_q[p].size() == 0)
                else note_error($sformatf("no last byte seen on port %0d before timeout", p));
            assert (credits[p] == BW)
                else note_error($sformatf("credits of port %0d not back before timeout", p));
        end
    endtask

    ////////////////////////////////////////
    // Directed tests

    task automatic test_routing();
        test_name = "routing";
        clear_tallies();
        for (int p = 0; p < NP; p++) begin
            make_packet(p, 3 + 7 * p, 1'b1);
        end
        send_all();
        wait_idle();
        for (int p = 0; p < NP; p++) begin
            check_eq($sformatf("packets on port %0d", p), 1, 32'(pkts_done[p]));
        end
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        clear_tallies();
        out_ready[1] = 1'b0;
        make_packet(1, BW * NB, 1'b1);
        send_all();
        out_ready[1] = 1'b1;
        wait_idle();
        check_eq("buf_full_drop pulses", 0, 32'(bfd_total[1]));
        check_eq("credit pulses", 32'(words_sent[1]), 32'(cr_total[1]));
    endtask

    task automatic test_disabled();
        test_name = "disabled";
        clear_tallies();
        port_enable[2] = 1'b0;
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < NP; p++) begin
                make_packet(p, 1 + int'(next_rand() % 32'd30), p != 2);
            end
            send_all();
        end
        wait_idle();
        port_enable[2] = 1'b1;
        check_eq("drop_cnt of port 2", 2, 32'(drop_cnt[2]));
        for (int p = 0; p < NP; p++) begin
            check_eq($sformatf("credits of port %0d", p), 32'(words_sent[p]),
                     32'(cr_total[p]));
        end
    endtask

    task automatic test_counters();
        test_name = "counters";
        cnt_clear = '1;
        @(negedge core_clk_ifc);
        cnt_clear = '0;
        for (int r = 0; r < 3; r++) begin
            for (int p = 0; p < NP; p++) begin
                make_packet(p, 1 + int'(next_rand() % 32'd40), 1'b1);
            end
            send_all();
        end
        // One dropped packet gives port 3 a drop count
        port_enable[3] = 1'b0;
        make_packet(3, 10, 1'b0);
        send_all();
        wait_idle();
        port_enable[3] = 1'b1;
        for (int p = 0; p < NP; p++) begin
            check_eq($sformatf("pkt_cnt of port %0d", p), 3, 32'(pkt_cnt[p]));
        end
        check_eq("drop_cnt of port 3", 1, 32'(drop_cnt[3]));
        // Port 3 holds both kinds of count
        cnt_clear[3] = 1'b1;
        @(negedge core_clk_ifc);
        cnt_clear[3] = 1'b0;
        for (int p = 0; p < NP; p++) begin
            check_eq($sformatf("pkt_cnt of port %0d after clear", p),
                     (p == 3) ? 0 : 3, 32'(pkt_cnt[p]));
            check_eq($sformatf("drop_cnt of port %0d after clear", p), 0,
                     32'(drop_cnt[p]));
        end
    endtask

    task automatic test_full_drop();
        int t;
        test_name = "full_drop";
        clear_tallies();
        t = 0;
        out_ready[3] = 1'b0;
        make_packet(3, (BW + 1) * NB, 1'b1);
        // The extra word never reaches the port
        repeat (NB) begin
            void'(exp_q[3].pop_back());
        end
        for (int w = 0; w <= BW; w++) begin
            send_next_word(3, w < BW);
        end
        while (bfd_total[3] == 0 && t < TIMEOUT) begin
            @(negedge core_clk_ifc);
            t++;
        end
        check_eq("buf_full_drop pulses", 1, 32'(bfd_total[3]));
        out_ready[3] = 1'b1;
        credits[3]++;
        wait_idle();
        check_eq("credit pulses", BW, 32'(cr_total[3]));
    endtask

    initial begin
        core_clk_ifc = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_word      = '0;
        port_enable  = '1;
        out_ready    = '1;
        cnt_clear    = '0;
        lcg_state    = 32'h516d_3384;
        n_value_err  = 0;
        n_other_err  = 0;
        for (int p = 0; p < NP; p++) begin
            credits[p] = BW;
        end
        repeat (4) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        rst_n = 1'b1;
        test_routing();
        test_backpressure();
        test_disabled();
        test_counters();
        test_full_drop();
        $display("Errors: %0d wrong value, %0d other", n_value_err, n_other_err);
        if (n_value_err + n_other_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: egress_router.f
+incdir+include
hw/egress_pkg.sv
hw/egress_demux.sv
hw/egress_port_buffer.sv
hw/egress_pkt_counters.sv
hw/egress_router.sv
dv/egress_router_assertions.sv
dv/egress_router_tb.sv

// File: Makefile
# Verilator build and run of the egress router testbench
VERILATOR  ?= verilator
TOP        ?= egress_router_tb
FILELIST   ?= egress_router.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
PASS_MSG   ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
